/* common/uart_settings.svh */
// UART core settings

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Data bits per frame
// Frame is start bit, data bits LSB first, one stop bit
`define UART_DATA_LEN 8

// Width of the bit period counter and of the config field
`define UART_DIV_WIDTH 16

// Bit period after reset, in clock cycles
// 10 MHz clock at 115200 baud gives 87
`define UART_DEFAULT_CLKS_PER_BIT 87

// Smallest bit period the config block accepts
// Anything lower leaves too few cycles for the mid-bit check
`define UART_MIN_CLKS_PER_BIT 4

`endif

/* common/uart_pkg.sv */
// UART line-side types

`include "uart_settings.svh"

package uart_pkg;

	// Receiver FSM states
	// Finish lasts one cycle and carries the valid pulse
	typedef enum logic [2:0]
	{
		rx_idle      = 3'd0,
		rx_start_bit = 3'd1,
		rx_data_bits = 3'd2,
		rx_stop_bit  = 3'd3,
		rx_finish    = 3'd4
	} rx_state_t;

	// Transmitter FSM states
	// Idle is the only state with the line free for a new byte
	typedef enum logic [1:0]
	{
		tx_idle      = 2'd0,
		tx_start_bit = 2'd1,
		tx_data_bits = 2'd2,
		tx_stop_bit  = 2'd3
	} tx_state_t;

	// Received word as seen on the rx_valid pulse
	// frame_error set when the stop bit was sampled low
	typedef struct packed
	{
		logic                      frame_error;
		logic [`UART_DATA_LEN-1:0] data;
	} rx_word_t;

endpackage

/* common/uart_cfg_pkg.sv */
// UART configuration types

`include "uart_settings.svh"

package uart_cfg_pkg;

	// Config write opcodes
	// Set period loads cfg_data as the bit period
	// Set enables takes bit 0 for rx and bit 1 for tx
	typedef enum logic
	{
		cfg_set_period  = 1'b0,
		cfg_set_enables = 1'b1
	} cfg_op_t;

	// Live configuration shared by both paths
	// Each path latches clks_per_bit when it leaves idle
	typedef struct packed
	{
		logic [`UART_DIV_WIDTH-1:0] clks_per_bit;
		logic                       rx_enable;
		logic                       tx_enable;
	} uart_cfg_t;

endpackage

/* source/uart_config.sv */
// UART configuration registers

`timescale 1ns/100ps

`include "uart_settings.svh"

module uart_config import uart_cfg_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       cfg_write,
	input  cfg_op_t                    cfg_op,
	input  logic [`UART_DIV_WIDTH-1:0] cfg_data,
	output uart_cfg_t                  cfg
);

	// Bounds for the bit period field
	localparam logic [`UART_DIV_WIDTH-1:0] min_period =
		`UART_DIV_WIDTH'(`UART_MIN_CLKS_PER_BIT);
	localparam logic [`UART_DIV_WIDTH-1:0] default_period =
		`UART_DIV_WIDTH'(`UART_DEFAULT_CLKS_PER_BIT);

	// Requested period after clamping to the minimum
	logic [`UART_DIV_WIDTH-1:0] clamped_period;

	assign clamped_period = (cfg_data < min_period) ? min_period : cfg_data;

	// Register file, one write per strobe
	// New values are visible on the next cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Default period, both paths on
			cfg.clks_per_bit <= default_period;
			cfg.rx_enable    <= 1'b1;
			cfg.tx_enable    <= 1'b1;
		end
		else if (cfg_write)
		begin
			case (cfg_op)
				cfg_set_period:
				begin
					cfg.clks_per_bit <= clamped_period;
				end
				cfg_set_enables:
				begin
					// Upper data bits ignored
					cfg.rx_enable <= cfg_data[0];
					cfg.tx_enable <= cfg_data[1];
				end
			endcase
		end
	end

endmodule

/* uart_rx/uart_rx.sv */
// UART 8N1 receiver

`timescale 1ns/100ps

`include "uart_settings.svh"

module uart_rx import uart_pkg::*, uart_cfg_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      serial_in,
	input  uart_cfg_t cfg,
	output logic      rx_valid,
	output rx_word_t  rx_word
);

	localparam int bit_count_width = $clog2(`UART_DATA_LEN);
	localparam logic [bit_count_width-1:0] last_bit =
		bit_count_width'(`UART_DATA_LEN - 1);

	// Two-flop synchronizer on the line
	logic rx_sync_1;
	logic rx_sync_2;

	// FSM and counters
	rx_state_t                  state;
	logic [`UART_DIV_WIDTH-1:0] clk_count;
	logic [bit_count_width-1:0] bit_count;

	// Bit period held for the whole frame
	logic [`UART_DIV_WIDTH-1:0] period;
	logic [`UART_DIV_WIDTH-1:0] half_period;
	logic [`UART_DIV_WIDTH-1:0] last_count;

	// Data bits collected so far
	logic [`UART_DATA_LEN-1:0] rx_data;

	// Frame events
	logic start_frame;
	logic sample_bit;
	logic stop_done;

	// Line idles high, so reset to high to avoid a false start
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_sync_1 <= 1'b1;
			rx_sync_2 <= 1'b1;
		end
		else
		begin
			rx_sync_1 <= serial_in;
			rx_sync_2 <= rx_sync_1;
		end
	end

	// Mid-bit of the start bit, then full periods to each data bit centre
	assign half_period = (period - 1'b1) >> 1;
	assign last_count  = period - 1'b1;

	// Falling edge seen while enabled
	assign start_frame = (state == rx_idle) && cfg.rx_enable && !rx_sync_2;
	assign sample_bit  = (state == rx_data_bits) && (clk_count == last_count);
	assign stop_done   = (state == rx_stop_bit) && (clk_count == last_count);

	// Period latch, data capture and result word
	always_ff @(posedge clk)
	begin
		if (start_frame)
			period <= cfg.clks_per_bit;
		// LSB arrives first
		if (sample_bit)
			rx_data[bit_count] <= rx_sync_2;
		// Low stop bit still reported, with the error flag
		if (stop_done)
			rx_word <= '{frame_error: !rx_sync_2, data: rx_data};
	end

	// Receive FSM
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= rx_idle;
			clk_count <= '0;
			bit_count <= '0;
			rx_valid  <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			case (state)
				rx_idle:
				begin
					clk_count <= '0;
					if (start_frame)
						state <= rx_start_bit;
				end
				rx_start_bit:
				begin
					// Line must still be low at mid-bit, else it was a glitch
					if (clk_count < half_period)
						clk_count <= clk_count + 1'b1;
					else
					begin
						clk_count <= '0;
						bit_count <= '0;
						state     <= rx_sync_2 ? rx_idle : rx_data_bits;
					end
				end
				rx_data_bits:
				begin
					if (!sample_bit)
						clk_count <= clk_count + 1'b1;
					else
					begin
						clk_count <= '0;
						if (bit_count == last_bit)
							state <= rx_stop_bit;
						else
							bit_count <= bit_count + 1'b1;
					end
				end
				rx_stop_bit:
				begin
					// Sampled at mid stop bit, result leaves one cycle later
					if (!stop_done)
						clk_count <= clk_count + 1'b1;
					else
					begin
						clk_count <= '0;
						rx_valid  <= 1'b1;
						state     <= rx_finish;
					end
				end
				rx_finish:
				begin
					// One cycle here, then ready for the next edge
					state <= rx_idle;
				end
				default:
				begin
					state     <= rx_idle;
					clk_count <= '0;
					bit_count <= '0;
				end
			endcase
		end
	end

endmodule

/* uart_tx/uart_tx.sv */
// UART 8N1 transmitter

`timescale 1ns/100ps

`include "uart_settings.svh"

module uart_tx import uart_pkg::*, uart_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  uart_cfg_t                 cfg,
	input  logic                      tx_start,
	input  logic [`UART_DATA_LEN-1:0] tx_data,
	output logic                      serial_out,
	output logic                      tx_busy
);

	localparam int bit_count_width = $clog2(`UART_DATA_LEN);
	localparam logic [bit_count_width-1:0] last_bit =
		bit_count_width'(`UART_DATA_LEN - 1);

	// FSM and counters
	tx_state_t                  state;
	logic [`UART_DIV_WIDTH-1:0] clk_count;
	logic [bit_count_width-1:0] bit_count;

	// Byte and period held for the frame
	logic [`UART_DATA_LEN-1:0]  tx_byte;
	logic [`UART_DIV_WIDTH-1:0] period;
	logic [`UART_DIV_WIDTH-1:0] last_count;

	logic start_accept;
	logic bit_end;

	// Strobes while busy or disabled are dropped
	assign start_accept = (state == tx_idle) && tx_start && cfg.tx_enable;
	assign last_count   = period - 1'b1;
	assign bit_end      = (clk_count == last_count);

	always_ff @(posedge clk)
	begin
		if (start_accept)
		begin
			tx_byte <= tx_data;
			period  <= cfg.clks_per_bit;
		end
	end

	// Transmit FSM, line and busy registered
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= tx_idle;
			clk_count  <= '0;
			bit_count  <= '0;
			serial_out <= 1'b1;
			tx_busy    <= 1'b0;
		end
		else
		begin
			case (state)
				tx_idle:
				begin
					if (start_accept)
					begin
						// Start bit goes out the next cycle
						state      <= tx_start_bit;
						clk_count  <= '0;
						serial_out <= 1'b0;
						tx_busy    <= 1'b1;
					end
				end
				tx_start_bit:
				begin
					if (!bit_end)
						clk_count <= clk_count + 1'b1;
					else
					begin
						state      <= tx_data_bits;
						clk_count  <= '0;
						bit_count  <= '0;
						serial_out <= tx_byte[0];
					end
				end
				tx_data_bits:
				begin
					if (!bit_end)
						clk_count <= clk_count + 1'b1;
					else
					begin
						clk_count <= '0;
						if (bit_count == last_bit)
						begin
							state      <= tx_stop_bit;
							serial_out <= 1'b1;
						end
						else
						begin
							bit_count  <= bit_count + 1'b1;
							serial_out <= tx_byte[bit_count + 1'b1];
						end
					end
				end
				tx_stop_bit:
				begin
					// Busy drops as the stop bit ends; line stays high
					if (!bit_end)
						clk_count <= clk_count + 1'b1;
					else
					begin
						state     <= tx_idle;
						clk_count <= '0;
						tx_busy   <= 1'b0;
					end
				end
				default:
				begin
					state      <= tx_idle;
					serial_out <= 1'b1;
					tx_busy    <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* source/uart_top.sv */
// UART core top level

`timescale 1ns/100ps

`include "uart_settings.svh"

module uart_top import uart_pkg::*, uart_cfg_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	// Configuration writes
	input  logic                       cfg_write,
	input  cfg_op_t                    cfg_op,
	input  logic [`UART_DIV_WIDTH-1:0] cfg_data,
	// Transmit side
	input  logic                       tx_start,
	input  logic [`UART_DATA_LEN-1:0]  tx_data,
	output logic                       serial_out,
	output logic                       tx_busy,
	// Receive side
	input  logic                       serial_in,
	output logic                       rx_valid,
	output rx_word_t                   rx_word
);

	// Shared configuration to both paths
	uart_cfg_t cfg;

	uart_config u_config
	(
		.clk       (clk),
		.reset     (reset),
		.cfg_write (cfg_write),
		.cfg_op    (cfg_op),
		.cfg_data  (cfg_data),
		.cfg       (cfg)
	);

	uart_rx u_rx
	(
		.clk       (clk),
		.reset     (reset),
		.serial_in (serial_in),
		.cfg       (cfg),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word)
	);

	uart_tx u_tx
	(
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.serial_out (serial_out),
		.tx_busy    (tx_busy)
	);

endmodule

/* bench/tb_clock.sv */
// Testbench clock and reset

`timescale 1ns/100ps

module tb_clock
#(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 8
)
(
	output logic clk,
	output logic reset
);

	// Free-running clock, low for the first half period
	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Reset held for the set number of rising edges
	// Released a quarter period after an edge, away from both edges
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#(period_ns / 4);
		reset = 1'b0;
	end

endmodule

/* bench/tb_uart.sv */
// UART core testbench

`timescale 1ns/100ps

`include "uart_settings.svh"

module tb_uart import uart_pkg::*, uart_cfg_pkg::*;
();

	localparam int clk_period_ns = 100;
	localparam int num_tests     = 13;
	localparam int idx_width     = $clog2(num_tests);
	// Largest bit period in the table
	localparam int max_div       = 87;
	localparam int wd_margin     = 2;
	localparam int watchdog_ns   = num_tests * 11 * max_div * clk_period_ns * wd_margin;
	localparam logic [31:0] lfsr_seed = 32'h911a;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	// How each entry drives the line
	typedef enum logic [2:0]
	{
		mode_idle,
		mode_loop,
		mode_bad_stop,
		mode_glitch,
		mode_rx_off,
		mode_busy
	} test_mode_t;

	// One stimulus row with its expected result
	typedef struct packed
	{
		logic [`UART_DIV_WIDTH-1:0] set_period;
		logic [`UART_DIV_WIDTH-1:0] eff_period;
		logic [`UART_DATA_LEN-1:0]  data;
		logic                       use_random;
		test_mode_t                 mode;
		logic                       expect_pulse;
		logic                       expect_error;
	} test_entry_t;

	// set_period of zero keeps the current period
	// eff_period is the period after clamping to the minimum
	localparam test_entry_t test_table [num_tests] = '{
		'{16'd0,  16'd87, 8'h00, 1'b0, mode_idle,     1'b0, 1'b0},
		'{16'd0,  16'd87, 8'h55, 1'b0, mode_loop,     1'b1, 1'b0},
		'{16'd0,  16'd87, 8'ha3, 1'b0, mode_loop,     1'b1, 1'b0},
		'{16'd0,  16'd87, 8'h00, 1'b1, mode_loop,     1'b1, 1'b0},
		'{16'd0,  16'd87, 8'h00, 1'b1, mode_loop,     1'b1, 1'b0},
		'{16'd16, 16'd16, 8'h3c, 1'b0, mode_loop,     1'b1, 1'b0},
		'{16'd0,  16'd16, 8'h00, 1'b1, mode_loop,     1'b1, 1'b0},
		'{16'd2,  16'd4,  8'hc9, 1'b0, mode_loop,     1'b1, 1'b0},
		'{16'd0,  16'd4,  8'h00, 1'b1, mode_loop,     1'b1, 1'b0},
		'{16'd16, 16'd16, 8'h6e, 1'b0, mode_bad_stop, 1'b1, 1'b1},
		'{16'd0,  16'd16, 8'h00, 1'b0, mode_glitch,   1'b0, 1'b0},
		'{16'd0,  16'd16, 8'h5a, 1'b0, mode_rx_off,   1'b0, 1'b0},
		'{16'd0,  16'd16, 8'h81, 1'b0, mode_busy,     1'b1, 1'b0}
	};

	logic clk;
	logic reset;

	// DUT inputs
	logic                       cfg_write;
	cfg_op_t                    cfg_op;
	logic [`UART_DIV_WIDTH-1:0] cfg_data;
	logic                       tx_start;
	logic [`UART_DATA_LEN-1:0]  tx_data;
	logic                       serial_in;

	// DUT outputs
	logic     serial_out;
	logic     tx_busy;
	logic     rx_valid;
	rx_word_t rx_word;

	// Line mux, loopback or bench-driven waveform
	logic loopback;
	logic bench_line;

	// Monitor state, written on the falling edge only
	int       rx_count;
	rx_word_t rx_last;
	int       busy_cycles;
	logic     busy_now;

	int          error_count;
	int          fail_count;
	logic [31:0] lfsr_state;

	tb_clock #(.period_ns(clk_period_ns), .reset_cycles(8)) clock_gen
	(
		.clk   (clk),
		.reset (reset)
	);

	assign serial_in = loopback ? serial_out : bench_line;

	uart_top UUT
	(
		.clk        (clk),
		.reset      (reset),
		.cfg_write  (cfg_write),
		.cfg_op     (cfg_op),
		.cfg_data   (cfg_data),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.serial_out (serial_out),
		.tx_busy    (tx_busy),
		.serial_in  (serial_in),
		.rx_valid   (rx_valid),
		.rx_word    (rx_word)
	);

	// DUT outputs are stable at the falling edge
	// Pulses counted here, read by the main flow on the rising edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			rx_count    <= 0;
			rx_last     <= '0;
			busy_cycles <= 0;
			busy_now    <= 1'b0;
		end
		else
		begin
			busy_now <= tx_busy;
			if (rx_valid)
			begin
				rx_count <= rx_count + 1;
				rx_last  <= rx_word;
			end
			if (tx_busy)
				busy_cycles <= busy_cycles + 1;
		end
	end

	function automatic string test_name(input int idx);
		case (idx)
			0:       return "reset_idle";
			1:       return "loop_55";
			2:       return "loop_a3";
			3:       return "loop_rand_a";
			4:       return "loop_rand_b";
			5:       return "div16_3c";
			6:       return "div16_rand";
			7:       return "div2_clamped";
			8:       return "div4_rand";
			9:       return "bad_stop";
			10:      return "short_glitch";
			11:      return "rx_disabled";
			12:      return "busy_start";
			default: return "unknown";
		endcase
	endfunction

	// Galois step, shifts right and folds the taps back in
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ lfsr_taps;
		else
			return s >> 1;
	endfunction

	// One LFSR step per bit, first bit taken lands in bit 0
	task automatic random_byte(output logic [`UART_DATA_LEN-1:0] value);
		value = '0;
		repeat (`UART_DATA_LEN)
		begin
			value      = {lfsr_state[0], value[`UART_DATA_LEN-1:1]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic report_value(input int idx, input string what, input int expected,
		input int actual);
		$display("ERR %s %s expected %0h actual %0h", test_name(idx), what, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input int idx, input string what);
		$display("%s: %s", test_name(idx), what);
		error_count++;
	endtask

	task automatic write_cfg(input cfg_op_t op, input logic [`UART_DIV_WIDTH-1:0] value);
		@(negedge clk);
		cfg_write = 1'b1;
		cfg_op    = op;
		cfg_data  = value;
		@(negedge clk);
		cfg_write = 1'b0;
	endtask

	task automatic send_byte(input logic [`UART_DATA_LEN-1:0] value);
		@(negedge clk);
		tx_start = 1'b1;
		tx_data  = value;
		@(negedge clk);
		tx_start = 1'b0;
	endtask

	// Start bit, data LSB first, then the given stop level, p cycles each
	task automatic drive_frame(input logic [`UART_DATA_LEN-1:0] value, input logic stop_level,
		input int p);
		logic [`UART_DATA_LEN+1:0] frame;
		frame = {stop_level, value, 1'b0};
		repeat (`UART_DATA_LEN + 2)
		begin
			@(negedge clk);
			bench_line = frame[0];
			frame      = frame >> 1;
			repeat (p - 1) @(negedge clk);
		end
		@(negedge clk);
		bench_line = 1'b1;
	endtask

	// Returns early once a new pulse has been counted
	task automatic wait_rx(input int mark, input int limit);
		int n;
		n = 0;
		while (n < limit && rx_count == mark)
		begin
			@(posedge clk);
			n++;
		end
	endtask

	// Done once busy has been seen and has fallen again
	task automatic wait_tx_idle(input int mark, input int limit, output logic done);
		int n;
		done = 1'b0;
		for (n = 0; n < limit && !done; n++)
		begin
			@(posedge clk);
			if (busy_cycles != mark && !busy_now)
				done = 1'b1;
		end
	endtask

	task automatic run_test(input int idx);
		test_entry_t               t;
		logic [`UART_DATA_LEN-1:0] value;
		logic [`UART_DATA_LEN:0]   expected_word;
		int                        p;
		int                        rx_mark;
		int                        busy_mark;
		int                        errors_before;
		logic                      done;
		t             = test_table[idx_width'(idx)];
		p             = int'(t.eff_period);
		errors_before = error_count;
		if (t.set_period != '0)
			write_cfg(cfg_set_period, t.set_period);
		value = t.data;
		if (t.use_random)
			random_byte(value);
		expected_word = {t.expect_error, value};
		// Snapshot the monitor away from its update edge
		@(posedge clk);
		rx_mark   = rx_count;
		busy_mark = busy_cycles;
		case (t.mode)
			mode_idle:
			begin
				@(negedge clk);
				if (serial_out !== 1'b1)
					report_value(idx, "serial_out", 1, int'(serial_out));
				if (tx_busy !== 1'b0)
					report_value(idx, "tx_busy", 0, int'(tx_busy));
				// One idle frame time with nothing on the line
				repeat (10 * p) @(posedge clk);
			end
			mode_loop, mode_busy:
			begin
				send_byte(value);
				if (t.mode == mode_busy)
				begin
					// Second strobe in mid-frame with a different byte
					repeat (3 * p) @(negedge clk);
					tx_start = 1'b1;
					tx_data  = ~value;
					@(negedge clk);
					tx_start = 1'b0;
				end
				wait_tx_idle(busy_mark, 11 * p + 8, done);
				if (!done)
					report_failure(idx, "the transmitter did not finish a frame in time");
				else if (busy_cycles - busy_mark != 10 * p)
					report_value(idx, "busy cycles", 10 * p, busy_cycles - busy_mark);
				wait_rx(rx_mark, 2 * p + 8);
				// A queued second byte would show up in this window
				if (t.mode == mode_busy)
					repeat (11 * p) @(posedge clk);
			end
			mode_bad_stop:
			begin
				@(negedge clk);
				loopback = 1'b0;
				drive_frame(value, 1'b0, p);
				wait_rx(rx_mark, 2 * p);
				// Low stop bit may look like a start edge, let it be rejected
				repeat (2 * p) @(posedge clk);
				@(negedge clk);
				loopback = 1'b1;
			end
			mode_glitch:
			begin
				@(negedge clk);
				loopback   = 1'b0;
				bench_line = 1'b0;
				repeat (p / 4 - 1) @(negedge clk);
				bench_line = 1'b1;
				repeat (12 * p) @(posedge clk);
				@(negedge clk);
				loopback = 1'b1;
			end
			mode_rx_off:
			begin
				// Transmit on, receive off
				write_cfg(cfg_set_enables, `UART_DIV_WIDTH'(2));
				loopback = 1'b0;
				drive_frame(value, 1'b1, p);
				repeat (2 * p) @(posedge clk);
				write_cfg(cfg_set_enables, `UART_DIV_WIDTH'(3));
				loopback = 1'b1;
			end
			default:
			begin
				report_failure(idx, "the table holds an unknown test mode");
			end
		endcase
		@(posedge clk);
		if (t.expect_pulse)
		begin
			if (rx_count == rx_mark)
				report_failure(idx, "no rx_valid pulse arrived for the frame");
			else
			begin
				if (rx_count - rx_mark != 1)
					report_value(idx, "rx_valid pulses", 1, rx_count - rx_mark);
				if (rx_last !== expected_word)
					report_value(idx, "rx_word", int'(expected_word), int'(rx_last));
			end
		end
		else if (rx_count != rx_mark)
			report_value(idx, "rx_valid pulses", 0, rx_count - rx_mark);
		if (error_count == errors_before)
			$display("test %0d %s passed", idx, test_name(idx));
		else
		begin
			$display("test %0d %s failed", idx, test_name(idx));
			fail_count++;
		end
	endtask

	// Main flow
	initial
	begin
		cfg_write   = 1'b0;
		cfg_op      = cfg_set_period;
		cfg_data    = '0;
		tx_start    = 1'b0;
		tx_data     = '0;
		loopback    = 1'b1;
		bench_line  = 1'b1;
		lfsr_state  = lfsr_seed;
		error_count = 0;
		fail_count  = 0;
		wait (reset == 1'b0);
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			num_tests, num_tests - fail_count, fail_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Eleven bit periods per entry at the largest period, doubled
	initial
	begin
		#(watchdog_ns);
		$display("watchdog timeout, the tests did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* compile.f */
+incdir+common
common/uart_pkg.sv
common/uart_cfg_pkg.sv
source/uart_config.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
source/uart_top.sv
bench/tb_clock.sv
bench/tb_uart.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_uart \
	-f compile.f -o sim_uart

output=$(./obj_dir/sim_uart)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
else
	exit 1
fi
